/* compile.f */
+incdir+sim
logic/csr_pkg.sv
logic/irq_sync.sv
logic/csr_exec.sv
logic/csr_regfile.sv
logic/csr_unit.sv
sim/csr_tb.sv

/* logic/csr_exec.sv */
//////////////////////////////////////////////////
// CSR instruction sequencer, one op in flight
// IDLE accepts, COMPUTE reads, STORE writes back
//////////////////////////////////////////////////

module csr_exec
    import csr_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    // Instruction handshake
    input  logic      valid,
    output logic      ready,
    input  instr_t    instr,
    // Integer register file
    output reg_addr_t rs1_addr,
    input  xlen_t     rs1_val,
    output logic      rd_wr_en,
    output reg_addr_t rd_wr_addr,
    output xlen_t     rd_wr_val,
    // Register file access
    output csr_addr_t rd_addr,
    input  xlen_t     rdata,
    output csr_wr_t   csr_wr
);

    exec_state_e state;
    logic        accept;

    // Fields captured at acceptance
    csr_op_e     op_r;
    csr_addr_t   csr_addr_r;
    // rs1 index or zimm, same bits of the word
    reg_addr_t   src_r;
    xlen_t       rs1_val_r;

    logic        imm_op;
    xlen_t       src_val;
    xlen_t       new_val;
    logic        wr_due;

    // Registered write strobe and data
    logic        wr_en_r;
    xlen_t       wdata_r;

    //////////////////////////////////////////////////
    // Handshake and control FSM
    //////////////////////////////////////////////////

    assign ready  = (state == IDLE);
    assign accept = valid && ready;

    // rs1 index goes out early so rs1_val is ready at acceptance
    assign rs1_addr = instr[RS1_LSB +: $bits(reg_addr_t)];

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= IDLE;
            rd_wr_en <= 1'b0;
            wr_en_r  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= COMPUTE;
                    end
                end
                // Old value is on rdata now
                COMPUTE: begin
                    state    <= STORE;
                    rd_wr_en <= 1'b1;
                    wr_en_r  <= wr_due;
                end
                // Register file takes the write on this edge
                STORE: begin
                    state    <= IDLE;
                    rd_wr_en <= 1'b0;
                    wr_en_r  <= 1'b0;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Operand capture and result registers
    //////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (accept) begin
            op_r       <= csr_op_e'(instr[FUNCT3_LSB +: $bits(csr_op_e)]);
            csr_addr_r <= instr[CSR_LSB +: $bits(csr_addr_t)];
            src_r      <= instr[RS1_LSB +: $bits(reg_addr_t)];
            rs1_val_r  <= rs1_val;
            rd_wr_addr <= instr[RD_LSB +: $bits(reg_addr_t)];
        end
        if (state == COMPUTE) begin
            rd_wr_val <= rdata;
            wdata_r   <= new_val;
        end
    end

    // Immediate forms take zero-extended zimm
    assign imm_op  = (op_r inside {CSR_RWI, CSR_RSI, CSR_RCI});
    assign src_val = imm_op ? {{(XLEN-$bits(reg_addr_t)){1'b0}}, src_r} : rs1_val_r;

    // New value and write decision
    always_comb begin
        case (op_r)
            CSR_RW, CSR_RWI: begin
                new_val = src_val;
                wr_due  = 1'b1;
            end
            // Zero source means read only
            CSR_RS, CSR_RSI: begin
                new_val = rdata | src_val;
                wr_due  = (src_r != '0);
            end
            CSR_RC, CSR_RCI: begin
                new_val = rdata & ~src_val;
                wr_due  = (src_r != '0);
            end
            default: begin
                new_val = rdata;
                wr_due  = 1'b0;
            end
        endcase
    end

    // Address holds from acceptance through STORE
    assign rd_addr     = csr_addr_r;
    assign csr_wr.en   = wr_en_r;
    assign csr_wr.addr = csr_addr_r;
    assign csr_wr.data = wdata_r;

endmodule

/* logic/csr_pkg.sv */
//////////////////////////////////////////////////
// Shared widths, CSR map, masks and bus structs
// for the machine CSR unit, imported by every block
//////////////////////////////////////////////////

package csr_pkg;

    // Data path width
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     instr_t;
    typedef logic [11:0]     csr_addr_t;
    // Integer register index, also carries zimm
    typedef logic [4:0]      reg_addr_t;

    // Instruction field positions
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int CSR_LSB    = 20;

    // funct3 encodings of the Zicsr instructions
    typedef enum logic [2:0] {
        CSR_RW  = 3'b001,
        CSR_RS  = 3'b010,
        CSR_RC  = 3'b011,
        CSR_RWI = 3'b101,
        CSR_RSI = 3'b110,
        CSR_RCI = 3'b111
    } csr_op_e;

    typedef enum logic [1:0] {
        IDLE,
        COMPUTE,
        STORE
    } exec_state_e;

    //////////////////////////////////////////////////
    // Machine CSR addresses
    //////////////////////////////////////////////////

    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MISA     = 12'h301;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_MIP      = 12'h344;
    localparam csr_addr_t CSR_MHARTID  = 12'hF14;

    // Read-only constants
    localparam xlen_t MHART_ID   = 32'h0000_0000;
    // MXL=1 plus the I base ISA
    localparam xlen_t MISA_VALUE = 32'h4000_0100;

    // Writable fields only, WPRI bits read back zero
    localparam xlen_t MSTATUS_WMASK = 32'h807F_F9BB;
    // IALIGN=32 so low two bits stay clear
    localparam xlen_t MEPC_WMASK    = 32'hFFFF_FFFC;

    // Pending and enable bit positions
    localparam int MEI_BIT = 11;
    localparam int MTI_BIT = 7;
    localparam int MSI_BIT = 3;

    // Flops per interrupt synchronizer
    localparam int SYNC_DEPTH = 2;

    //////////////////////////////////////////////////
    // Bundles between blocks
    //////////////////////////////////////////////////

    // Instruction write port into the register file
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        xlen_t     data;
    } csr_wr_t;

    // Trap controller writes, highest priority
    typedef struct packed {
        logic  mstatus_wr;
        xlen_t mstatus;
        logic  mepc_wr;
        xlen_t mepc;
        logic  mcause_wr;
        xlen_t mcause;
        logic  mtval_wr;
        xlen_t mtval;
    } trap_wr_t;

    // Registers exported to the rest of the core
    typedef struct packed {
        xlen_t mtvec;
        xlen_t mepc;
        xlen_t mstatus;
        logic  meip;
        logic  mtip;
        logic  msip;
    } csr_sb_t;

endpackage

/* logic/csr_regfile.sv */
//////////////////////////////////////////////////
// Machine CSR storage with trap writes, pending
// interrupts, read mux and the shared bus
//////////////////////////////////////////////////

module csr_regfile
    import csr_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    // Writes from the sequencer and the trap controller
    input  csr_wr_t   csr_wr,
    input  trap_wr_t  trap_wr,
    // Combinational read port
    input  csr_addr_t rd_addr,
    output xlen_t     rdata,
    // Synchronized interrupt lines
    input  logic      irq_meip,
    input  logic      irq_mtip,
    input  logic      irq_msip,
    output csr_sb_t   csr_sb
);

    xlen_t mstatus;
    xlen_t mie;
    xlen_t mtvec;
    xlen_t mscratch;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t mtval;
    xlen_t mip;

    logic  irq_any;

    // Instruction write aimed at this address
    function automatic logic hit(csr_wr_t wr, csr_addr_t addr);
        return wr.en && (wr.addr == addr);
    endfunction

    // Trap value first, then instruction value, both masked
    function automatic xlen_t next_val(logic trap_en, xlen_t trap_val, logic wr_en,
                                       xlen_t wr_val, xlen_t mask, xlen_t cur);
        if (trap_en) begin
            return trap_val & mask;
        end
        if (wr_en) begin
            return wr_val & mask;
        end
        return cur;
    endfunction

    //////////////////////////////////////////////////
    // Trap-writable registers
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mstatus <= '0;
            mepc    <= '0;
            mcause  <= '0;
            mtval   <= '0;
        end else begin
            mstatus <= next_val(trap_wr.mstatus_wr, trap_wr.mstatus,
                                hit(csr_wr, CSR_MSTATUS), csr_wr.data,
                                MSTATUS_WMASK, mstatus);
            mepc    <= next_val(trap_wr.mepc_wr, trap_wr.mepc,
                                hit(csr_wr, CSR_MEPC), csr_wr.data,
                                MEPC_WMASK, mepc);
            // No masking on cause and tval
            mcause  <= next_val(trap_wr.mcause_wr, trap_wr.mcause,
                                hit(csr_wr, CSR_MCAUSE), csr_wr.data,
                                '1, mcause);
            mtval   <= next_val(trap_wr.mtval_wr, trap_wr.mtval,
                                hit(csr_wr, CSR_MTVAL), csr_wr.data,
                                '1, mtval);
        end
    end

    //////////////////////////////////////////////////
    // Software-only registers
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
        end else begin
            if (hit(csr_wr, CSR_MIE)) begin
                mie <= csr_wr.data;
            end
            if (hit(csr_wr, CSR_MTVEC)) begin
                mtvec <= csr_wr.data;
            end
            if (hit(csr_wr, CSR_MSCRATCH)) begin
                mscratch <= csr_wr.data;
            end
        end
    end

    //////////////////////////////////////////////////
    // Pending interrupts
    //////////////////////////////////////////////////

    assign irq_any = irq_meip || irq_mtip || irq_msip;

    // Any live line locks out software writes to mip
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mip <= '0;
        end else if (irq_any) begin
            // Sticky set when enabled
            if (irq_meip && mie[MEI_BIT]) begin
                mip[MEI_BIT] <= 1'b1;
            end
            if (irq_mtip && mie[MTI_BIT]) begin
                mip[MTI_BIT] <= 1'b1;
            end
            if (irq_msip && mie[MSI_BIT]) begin
                mip[MSI_BIT] <= 1'b1;
            end
        end else if (hit(csr_wr, CSR_MIP)) begin
            mip <= csr_wr.data;
        end
    end

    //////////////////////////////////////////////////
    // Read mux and shared bus
    //////////////////////////////////////////////////

    // Unmapped addresses read zero
    always_comb begin
        case (rd_addr)
            CSR_MSTATUS:  rdata = mstatus;
            CSR_MISA:     rdata = MISA_VALUE;
            CSR_MIE:      rdata = mie;
            CSR_MTVEC:    rdata = mtvec;
            CSR_MSCRATCH: rdata = mscratch;
            CSR_MEPC:     rdata = mepc;
            CSR_MCAUSE:   rdata = mcause;
            CSR_MTVAL:    rdata = mtval;
            CSR_MIP:      rdata = mip;
            CSR_MHARTID:  rdata = MHART_ID;
            default:      rdata = '0;
        endcase
    end

    assign csr_sb.mtvec   = mtvec;
    assign csr_sb.mepc    = mepc;
    assign csr_sb.mstatus = mstatus;
    assign csr_sb.meip    = mip[MEI_BIT];
    assign csr_sb.mtip    = mip[MTI_BIT];
    assign csr_sb.msip    = mip[MSI_BIT];

endmodule

/* logic/csr_unit.sv */
//////////////////////////////////////////////////
// Machine CSR unit top, instruction port in,
// writeback and shared bus out
//////////////////////////////////////////////////

module csr_unit
    import csr_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    // Interrupt pins, asynchronous
    input  logic      ext_irq,
    input  logic      sw_irq,
    input  logic      timer_irq,
    // Instruction handshake
    input  logic      valid,
    output logic      ready,
    input  instr_t    instr,
    // Integer register file side
    output reg_addr_t rs1_addr,
    input  xlen_t     rs1_val,
    output logic      rd_wr_en,
    output reg_addr_t rd_wr_addr,
    output xlen_t     rd_wr_val,
    // Trap controller and core-wide bus
    input  trap_wr_t  trap_wr,
    output csr_sb_t   csr_sb
);

    csr_wr_t   csr_wr;
    csr_addr_t rd_addr;
    xlen_t     rdata;
    logic      irq_meip;
    logic      irq_mtip;
    logic      irq_msip;

    // Interrupt pins into aclk
    irq_sync irq_sync0 (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .ext_irq   (ext_irq),
        .sw_irq    (sw_irq),
        .timer_irq (timer_irq),
        .irq_meip  (irq_meip),
        .irq_mtip  (irq_mtip),
        .irq_msip  (irq_msip)
    );

    // Instruction sequencing and writeback
    csr_exec csr_exec0 (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .valid      (valid),
        .ready      (ready),
        .instr      (instr),
        .rs1_addr   (rs1_addr),
        .rs1_val    (rs1_val),
        .rd_wr_en   (rd_wr_en),
        .rd_wr_addr (rd_wr_addr),
        .rd_wr_val  (rd_wr_val),
        .rd_addr    (rd_addr),
        .rdata      (rdata),
        .csr_wr     (csr_wr)
    );

    // Register storage
    csr_regfile csr_regfile0 (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .csr_wr   (csr_wr),
        .trap_wr  (trap_wr),
        .rd_addr  (rd_addr),
        .rdata    (rdata),
        .irq_meip (irq_meip),
        .irq_mtip (irq_mtip),
        .irq_msip (irq_msip),
        .csr_sb   (csr_sb)
    );

endmodule

/* logic/irq_sync.sv */
//////////////////////////////////////////////////
// Brings the three asynchronous interrupt pins
// into the aclk domain through flop chains
//////////////////////////////////////////////////

module irq_sync
    import csr_pkg::*;
(
    input  logic aclk,
    input  logic aresetn,
    input  logic ext_irq,
    input  logic sw_irq,
    input  logic timer_irq,
    output logic irq_meip,
    output logic irq_mtip,
    output logic irq_msip
);

    // One stage per row, lines packed as {ext, timer, sw}
    logic [SYNC_DEPTH-1:0][2:0] sync_q;

    // Shift the pins in, oldest stage at the top
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_DEPTH-2:0], {ext_irq, timer_irq, sw_irq}};
        end
    end

    // Last stage feeds the pending logic
    assign irq_meip = sync_q[SYNC_DEPTH-1][2];
    assign irq_mtip = sync_q[SYNC_DEPTH-1][1];
    assign irq_msip = sync_q[SYNC_DEPTH-1][0];

endmodule

/* sim/csr_ref.svh */
//////////////////////////////////////////////////
// Reference CSR model and random source that the
// testbench includes in its module body
//////////////////////////////////////////////////

`ifndef CSR_REF_SVH
`define CSR_REF_SVH

// One entry per CSR address with unmapped ones held at zero
xlen_t       ref_csr [0:4095];
int unsigned lcg_state;

// Bits that software or a trap may change
function automatic xlen_t ref_wmask(csr_addr_t addr);
    case (addr)
        CSR_MSTATUS: return MSTATUS_WMASK;
        CSR_MEPC:    return MEPC_WMASK;
        CSR_MIE, CSR_MTVEC, CSR_MSCRATCH: return '1;
        CSR_MCAUSE, CSR_MTVAL, CSR_MIP:   return '1;
        // Constants and unknown addresses
        default:     return '0;
    endcase
endfunction

function automatic void ref_reset();
    int i;
    for (i = 0; i < 4096; i++) begin
        ref_csr[i] = '0;
    end
    ref_csr[CSR_MISA]    = MISA_VALUE;
    ref_csr[CSR_MHARTID] = MHART_ID;
    lcg_state = 85;
endfunction

// Returns the old value and updates the model if a write is due
function automatic xlen_t csr_ref_op(csr_op_e op, csr_addr_t addr, reg_addr_t src,
                                     xlen_t rs1v);
    xlen_t old_val;
    xlen_t operand;
    xlen_t new_val;
    xlen_t mask;
    logic  do_write;
    old_val  = ref_csr[addr];
    mask     = ref_wmask(addr);
    operand  = rs1v;
    do_write = (src != 0);
    new_val  = old_val;
    case (op)
        CSR_RW: begin
            new_val  = operand;
            do_write = 1'b1;
        end
        CSR_RS:  new_val = old_val | operand;
        CSR_RC:  new_val = old_val & ~operand;
        // Immediate forms take zimm zero extended
        CSR_RWI: begin
            new_val  = xlen_t'(src);
            do_write = 1'b1;
        end
        CSR_RSI: new_val = old_val | xlen_t'(src);
        CSR_RCI: new_val = old_val & ~xlen_t'(src);
        default: do_write = 1'b0;
    endcase
    if (do_write) begin
        ref_csr[addr] = (new_val & mask) | (old_val & ~mask);
    end
    return old_val;
endfunction

// Trap write lands after any instruction write on the same edge
function automatic void ref_trap(csr_addr_t addr, xlen_t val);
    ref_csr[addr] = val & ref_wmask(addr);
endfunction

// LCG step
function automatic int unsigned rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// Upper bits have the longer period
function automatic int unsigned rand_below(int unsigned n);
    return (rand_next() >> 16) % n;
endfunction

`endif

/* sim/csr_tb.sv */
//////////////////////////////////////////////////
// Testbench for the machine CSR unit with directed
// and random CSR ops checked against a reference model
//////////////////////////////////////////////////

module csr_tb
    import csr_pkg::*;
();

    localparam int WAIT_LIMIT = 20;
    localparam int RAND_OPS   = 200;

    // Expected writeback of one instruction
    typedef struct packed {
        reg_addr_t rd;
        xlen_t     val;
    } exp_wb_t;

    logic      aclk;
    logic      aresetn;
    logic      ext_irq;
    logic      sw_irq;
    logic      timer_irq;
    logic      valid;
    logic      ready;
    instr_t    instr;
    reg_addr_t rs1_addr;
    xlen_t     rs1_val;
    logic      rd_wr_en;
    reg_addr_t rd_wr_addr;
    xlen_t     rd_wr_val;
    trap_wr_t  trap_wr;
    csr_sb_t   csr_sb;

    // Integer register file model that feeds rs1_val
    xlen_t     xreg [0:31];
    exp_wb_t   exp_q [$];
    int        err_cnt;
    int        check_cnt;
    int        test_num;
    int        test_err_base;

    `include "csr_ref.svh"

    csr_unit dut0 (.*);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    //////////////////////////////////////////////////
    // Checking and reporting
    //////////////////////////////////////////////////

    task automatic check_val(input string name, input xlen_t got, input xlen_t exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic end_run();
        $display("tests %0d, checks %0d, errors %0d", test_num, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        err_cnt++;
        end_run();
    endtask

    task automatic test_begin();
        test_num++;
        test_err_base = err_cnt;
    endtask

    task automatic test_end(input string name);
        $display("test %0d %s: %0d errors", test_num, name, err_cnt - test_err_base);
    endtask

    // Compare every writeback pulse with the oldest expectation
    always @(posedge aclk) begin
        if (rd_wr_en) begin
            if (exp_q.size() == 0) begin
                $display("Writeback at %0t with no instruction outstanding", $time);
                err_cnt++;
            end else begin
                check_val("rd_wr_addr", xlen_t'(rd_wr_addr), xlen_t'(exp_q[0].rd));
                check_val("rd_wr_val", rd_wr_val, exp_q[0].val);
                void'(exp_q.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus helpers called on a rising edge
    //////////////////////////////////////////////////

    // Returns on the acceptance edge
    task automatic start_op(input csr_op_e op, input csr_addr_t addr, input reg_addr_t src,
                            input reg_addr_t rd);
        exp_wb_t exp;
        int      cycles;
        cycles  = 0;
        valid   <= 1'b1;
        instr   <= {addr, src, op, rd, 7'b1110011};
        rs1_val <= xreg[src];
        @(posedge aclk);
        // ready seen here is the value of the cycle just ended
        while (!ready && cycles < WAIT_LIMIT) begin
            @(posedge aclk);
            cycles++;
        end
        if (cycles >= WAIT_LIMIT) begin
            report_timeout("ready to accept an instruction");
        end
        // rs1 field of the accepted word goes to the register file
        check_val("rs1_addr", xlen_t'(rs1_addr), xlen_t'(src));
        valid   <= 1'b0;
        exp.rd  = rd;
        exp.val = csr_ref_op(op, addr, src, xreg[src]);
        exp_q.push_back(exp);
        if (rd != 0) begin
            xreg[rd] = exp.val;
        end
    endtask

    // Waits for ready after the writeback so the CSR update is visible
    task automatic finish_op();
        int cycles;
        cycles = 0;
        @(posedge aclk);
        while (!ready && cycles < WAIT_LIMIT) begin
            @(posedge aclk);
            cycles++;
        end
        if (!ready) begin
            report_timeout("ready after the writeback");
        end else if (exp_q.size() != 0) begin
            $display("No rd_wr_en writeback pulse before ready returned at %0t", $time);
            err_cnt++;
            exp_q.delete();
        end
    endtask

    task automatic do_op(input csr_op_e op, input csr_addr_t addr, input reg_addr_t src,
                         input reg_addr_t rd);
        start_op(op, addr, src, rd);
        finish_op();
    endtask

    function automatic csr_op_e pick_op();
        case (rand_below(6))
            0:       return CSR_RW;
            1:       return CSR_RS;
            2:       return CSR_RC;
            3:       return CSR_RWI;
            4:       return CSR_RSI;
            default: return CSR_RCI;
        endcase
    endfunction

    // Zero source a quarter of the time hits the read-only forms
    function automatic reg_addr_t pick_src();
        if (rand_below(4) == 0) begin
            return '0;
        end
        return reg_addr_t'(rand_below(32));
    endfunction

    task automatic rand_op(input csr_addr_t addr);
        reg_addr_t src;
        src = pick_src();
        if (src != 0) begin
            xreg[src] = rand_next();
        end
        do_op(pick_op(), addr, src, reg_addr_t'(rand_below(32)));
    endtask

    // CSRRW whose E2 write edge meets a trap write to the same CSR
    task automatic trap_race(input csr_addr_t addr);
        trap_wr_t  tw;
        xlen_t     tval;
        reg_addr_t src;
        src       = reg_addr_t'(rand_below(31) + 1);
        xreg[src] = rand_next();
        tval      = rand_next();
        tw        = '0;
        case (addr)
            CSR_MSTATUS: begin
                tw.mstatus_wr = 1'b1;
                tw.mstatus    = tval;
            end
            CSR_MEPC: begin
                tw.mepc_wr = 1'b1;
                tw.mepc    = tval;
            end
            default: begin
                tw.mcause_wr = 1'b1;
                tw.mcause    = tval;
            end
        endcase
        start_op(CSR_RW, addr, src, 5'd0);
        // Trap value set at E1 is sampled on the E2 edge
        @(posedge aclk);
        trap_wr <= tw;
        @(posedge aclk);
        trap_wr <= '0;
        ref_trap(addr, tval);
        finish_op();
        do_op(CSR_RS, addr, 5'd0, 5'd0);
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        trap_wr_t tw;
        int       i;
        int       cycles;
        err_cnt   = 0;
        check_cnt = 0;
        test_num  = 0;
        aresetn   = 1'b0;
        ext_irq   = 1'b0;
        sw_irq    = 1'b0;
        timer_irq = 1'b0;
        valid     = 1'b0;
        instr     = '0;
        rs1_val   = '0;
        trap_wr   = '0;
        ref_reset();
        xreg[0] = '0;
        for (i = 1; i < 32; i++) begin
            xreg[i] = rand_next();
        end
        repeat (4) @(posedge aclk);
        aresetn <= 1'b1;
        @(posedge aclk);

        // Reset state and read-only constants
        test_begin();
        check_val("ready", xlen_t'(ready), 1);
        check_val("rd_wr_en", xlen_t'(rd_wr_en), 0);
        check_val("csr_sb.mtvec", csr_sb.mtvec, 0);
        check_val("csr_sb.mepc", csr_sb.mepc, 0);
        check_val("csr_sb.mstatus", csr_sb.mstatus, 0);
        check_val("csr_sb.irq", xlen_t'({csr_sb.meip, csr_sb.mtip, csr_sb.msip}), 0);
        do_op(CSR_RS, CSR_MISA, 5'd0, 5'd1);
        do_op(CSR_RS, CSR_MHARTID, 5'd0, 5'd2);
        do_op(CSR_RS, 12'h7C0, 5'd0, 5'd3);
        do_op(CSR_RWI, CSR_MISA, 5'd5, 5'd4);
        do_op(CSR_RWI, 12'h7C0, 5'd9, 5'd5);
        do_op(CSR_RS, CSR_MISA, 5'd0, 5'd6);
        do_op(CSR_RS, CSR_MHARTID, 5'd0, 5'd7);
        do_op(CSR_RS, 12'h7C0, 5'd0, 5'd8);
        test_end("reset and constants");

        // Random ops on the plain read/write CSRs
        test_begin();
        for (i = 0; i < RAND_OPS; i++) begin
            case (rand_below(4))
                0:       rand_op(CSR_MSCRATCH);
                1:       rand_op(CSR_MTVEC);
                2:       rand_op(CSR_MIE);
                default: rand_op(CSR_MCAUSE);
            endcase
        end
        test_end("random ops");

        // Write masks and the shared bus
        test_begin();
        for (i = 0; i < 60; i++) begin
            case (rand_below(3))
                0:       rand_op(CSR_MSTATUS);
                1:       rand_op(CSR_MEPC);
                default: rand_op(CSR_MTVEC);
            endcase
            check_val("csr_sb.mstatus", csr_sb.mstatus, ref_csr[CSR_MSTATUS]);
            check_val("csr_sb.mepc", csr_sb.mepc, ref_csr[CSR_MEPC]);
            check_val("csr_sb.mtvec", csr_sb.mtvec, ref_csr[CSR_MTVEC]);
        end
        do_op(CSR_RS, CSR_MSTATUS, 5'd0, 5'd0);
        do_op(CSR_RS, CSR_MEPC, 5'd0, 5'd0);
        test_end("masked registers");

        // Trap writes while idle and racing an instruction
        test_begin();
        tw            = '0;
        tw.mstatus_wr = 1'b1;
        tw.mstatus    = rand_next();
        tw.mepc_wr    = 1'b1;
        tw.mepc       = rand_next();
        tw.mcause_wr  = 1'b1;
        tw.mcause     = rand_next();
        tw.mtval_wr   = 1'b1;
        tw.mtval      = rand_next();
        trap_wr <= tw;
        @(posedge aclk);
        trap_wr <= '0;
        ref_trap(CSR_MSTATUS, tw.mstatus);
        ref_trap(CSR_MEPC, tw.mepc);
        ref_trap(CSR_MCAUSE, tw.mcause);
        ref_trap(CSR_MTVAL, tw.mtval);
        do_op(CSR_RS, CSR_MSTATUS, 5'd0, 5'd1);
        do_op(CSR_RS, CSR_MEPC, 5'd0, 5'd2);
        do_op(CSR_RS, CSR_MCAUSE, 5'd0, 5'd3);
        do_op(CSR_RS, CSR_MTVAL, 5'd0, 5'd4);
        check_val("csr_sb.mstatus", csr_sb.mstatus, ref_csr[CSR_MSTATUS]);
        check_val("csr_sb.mepc", csr_sb.mepc, ref_csr[CSR_MEPC]);
        trap_race(CSR_MCAUSE);
        trap_race(CSR_MEPC);
        trap_race(CSR_MSTATUS);
        test_end("trap writes");

        // Only MTIE set while all three lines pulse
        test_begin();
        xreg[5] = xlen_t'(1) << MTI_BIT;
        do_op(CSR_RW, CSR_MIE, 5'd5, 5'd0);
        ext_irq   <= 1'b1;
        sw_irq    <= 1'b1;
        timer_irq <= 1'b1;
        cycles = 0;
        @(posedge aclk);
        while (!csr_sb.mtip && cycles < WAIT_LIMIT) begin
            check_val("csr_sb.meip", xlen_t'(csr_sb.meip), 0);
            check_val("csr_sb.msip", xlen_t'(csr_sb.msip), 0);
            @(posedge aclk);
            cycles++;
        end
        if (!csr_sb.mtip) begin
            report_timeout("csr_sb.mtip to rise");
        end
        ref_csr[CSR_MIP] = ref_csr[CSR_MIP] | (xlen_t'(1) << MTI_BIT);
        ext_irq   <= 1'b0;
        sw_irq    <= 1'b0;
        timer_irq <= 1'b0;
        // Let the synchronizers drain before touching mip
        repeat (SYNC_DEPTH + 1) @(posedge aclk);
        check_val("csr_sb.mtip", xlen_t'(csr_sb.mtip), 1);
        check_val("csr_sb.meip", xlen_t'(csr_sb.meip), 0);
        check_val("csr_sb.msip", xlen_t'(csr_sb.msip), 0);
        do_op(CSR_RC, CSR_MIP, 5'd5, 5'd7);
        check_val("csr_sb.mtip", xlen_t'(csr_sb.mtip), 0);
        do_op(CSR_RS, CSR_MIP, 5'd0, 5'd0);
        test_end("interrupt pending");

        end_run();
    end

endmodule
